// ==== Makefile ====
# Verilator build and run of the PIPE bring-up testbench

TOP = pipe_link_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/bringup_timer.sv ====
// ==========================================================
// done rises count cycles after the load cycle, count 0 acts as 1
// done is sticky until the next load
// ==========================================================
`timescale 1ns/1ps

module bringup_timer #(
   parameter int CNT_W = 16
) (
   input  logic             rxclk,
   input  logic             rst,
   input  logic             load,
   input  logic [CNT_W-1:0] count,
   output logic             done
);

   logic [CNT_W-1:0] remain;   // cycles left before done

   // ========================================================
   // down-counter
   // ========================================================
   always_ff @(posedge rxclk) begin
      if (rst) begin
         remain <= '0;
         done   <= 1'b0;
      end else if (load) begin
         // load cycle already counts as the first one
         remain <= count - 1'b1;
         done   <= (count <= 1);  // short waits finish right away
      end else if (!done) begin
         remain <= remain - 1'b1;
         if (remain == 1) begin
            done <= 1'b1;         // stays up, counter frozen
         end
      end
   end

endmodule

// ==== rtl/pipe_bringup_fsm.sv ====
// ==========================================================
// each timed wait must be 2 cycles or more and fit in CNT_W bits
// phystatus and rxstatus are taken as synchronous to rxclk
// ==========================================================
`timescale 1ns/1ps

module pipe_bringup_fsm #(
   parameter int PHY_RST_CYCLES     = 64,
   parameter int SETTLE_CYCLES      = 20,
   parameter int DETECT_HOLD_CYCLES = 5,
   parameter int P0_GAP_CYCLES      = 2,
   parameter int QUIET_CYCLES       = 100,
   parameter int CNT_W              = 16
) (
   input  logic                   rxclk,
   input  logic                   rst,
   input  logic                   phystatus,
   input  pipe_pkg::rx_status_t   rxstatus,
   input  logic                   training_enable,
   input  logic                   timer_done,
   output logic                   timer_load,
   output logic [CNT_W-1:0]       timer_count,
   output logic                   phy_reset_n,
   output pipe_pkg::power_state_t pwrdwn,
   output logic                   rxdet_loopb,
   output logic                   ts1_enable,
   output pipe_pkg::train_state_t state
);
   import pipe_pkg::*;

   // ========================================================
   // timer loads
   // ========================================================
   // load sits one cycle behind the state change and the outputs
   // follow done one cycle late, so every count is one short
   localparam logic [CNT_W-1:0] LD_RST    = CNT_W'(PHY_RST_CYCLES - 1);
   localparam logic [CNT_W-1:0] LD_SETTLE = CNT_W'(SETTLE_CYCLES - 1);
   localparam logic [CNT_W-1:0] LD_HOLD   = CNT_W'(DETECT_HOLD_CYCLES - 1);
   localparam logic [CNT_W-1:0] LD_GAP    = CNT_W'(P0_GAP_CYCLES - 1);
   localparam logic [CNT_W-1:0] LD_QUIET  = CNT_W'(QUIET_CYCLES - 1);

   logic phystatus_q;   // previous phystatus sample
   logic phy_fall;
   logic phy_rise;
   logic wait_over;     // fresh timer expiry, not the stale one

   assign phy_fall  = phystatus_q & ~phystatus;
   assign phy_rise  = ~phystatus_q & phystatus;
   // done is still set from the last wait while the load is pending
   assign wait_over = timer_done & ~timer_load;

   // training only once the link is in polling
   assign ts1_enable = (state == POLLING) & training_enable;

   always_ff @(posedge rxclk) begin
      if (rst) begin
         phystatus_q <= 1'b0;
      end else begin
         phystatus_q <= phystatus;
      end
   end

   // ========================================================
   // sequencer, all PHY controls registered
   // ========================================================
   always_ff @(posedge rxclk) begin
      if (rst) begin
         state       <= RST_HOLD;
         phy_reset_n <= 1'b0;
         pwrdwn      <= PWR_P1;
         rxdet_loopb <= 1'b0;
         timer_load  <= 1'b1;    // reset hold starts on the first free edge
         timer_count <= LD_RST;
      end else begin
         timer_load <= 1'b0;     // single-cycle strobe
         case (state)
            RST_HOLD: begin
               if (wait_over) begin
                  phy_reset_n <= 1'b1;
                  state       <= WAIT_PLL;
               end
            end
            WAIT_PLL: begin
               if (!phystatus) begin   // low means PLL locked
                  timer_load  <= 1'b1;
                  timer_count <= LD_SETTLE;
                  state       <= SETTLE;
               end
            end
            SETTLE: begin
               if (wait_over) begin
                  rxdet_loopb <= 1'b1;  // still in P1 here
                  state       <= DETECT;
               end
            end
            DETECT: begin
               if (phystatus && rxstatus == RX_DETECTED) begin
                  timer_load  <= 1'b1;
                  timer_count <= LD_HOLD;
                  state       <= DETECT_HOLD;
               end
            end
            DETECT_HOLD: begin
               if (wait_over) begin
                  rxdet_loopb <= 1'b0;
                  timer_load  <= 1'b1;
                  timer_count <= LD_GAP;
                  state       <= P0_GAP;
               end
            end
            P0_GAP: begin
               if (wait_over) begin
                  pwrdwn <= PWR_P0;
                  state  <= WAIT_P0_LOW;
               end
            end
            WAIT_P0_LOW: begin
               if (phy_fall) begin
                  state <= WAIT_P0_HIGH;
               end
            end
            WAIT_P0_HIGH: begin
               if (phy_rise) begin     // power change done
                  timer_load  <= 1'b1;
                  timer_count <= LD_QUIET;
                  state       <= QUIET;
               end
            end
            QUIET: begin
               if (wait_over) begin
                  state <= POLLING;
               end
            end
            POLLING: begin
               state <= POLLING;       // left only through rst
            end
            default: begin
               state <= RST_HOLD;
            end
         endcase
      end
   end

endmodule

// ==== rtl/pipe_link_top.sv ====
// ==========================================================
// single clock domain on rxclk, txclk is rxclk forwarded
// receive data path is not used, txcomp and rxpol held low
// ==========================================================
`timescale 1ns/1ps

module pipe_link_top #(
   parameter int         PHY_RST_CYCLES     = 64,
   parameter int         SETTLE_CYCLES      = 20,
   parameter int         DETECT_HOLD_CYCLES = 5,
   parameter int         P0_GAP_CYCLES      = 2,
   parameter int         QUIET_CYCLES       = 100,
   parameter logic [7:0] N_FTS              = 8'hF0,
   parameter int         CNT_W              = 16
) (
   input  logic                   rxclk,
   input  logic                   rst,
   input  logic                   phystatus,
   input  pipe_pkg::rx_status_t   rxstatus,
   input  logic                   training_enable,
   output logic                   txclk,
   output pipe_pkg::pipe_data_t   txdata16,
   output pipe_pkg::pipe_datak_t  txdatak16,
   output logic                   txidle16,
   output logic                   rxdet_loopb,
   output logic                   txcomp,
   output logic                   rxpol,
   output logic                   phy_reset_n,
   output pipe_pkg::power_state_t pwrdwn,
   output pipe_pkg::train_state_t train_state
);
   import pipe_pkg::*;

   logic             timer_load;
   logic [CNT_W-1:0] timer_count;
   logic             timer_done;
   logic             ts1_enable;
   pipe_tx_t         tx;          // generator beat

   // ========================================================
   // blocks
   // ========================================================
   pipe_bringup_fsm #(
      .PHY_RST_CYCLES    (PHY_RST_CYCLES),
      .SETTLE_CYCLES     (SETTLE_CYCLES),
      .DETECT_HOLD_CYCLES(DETECT_HOLD_CYCLES),
      .P0_GAP_CYCLES     (P0_GAP_CYCLES),
      .QUIET_CYCLES      (QUIET_CYCLES),
      .CNT_W             (CNT_W)
   ) fsm_inst (
      .rxclk          (rxclk),
      .rst            (rst),
      .phystatus      (phystatus),
      .rxstatus       (rxstatus),
      .training_enable(training_enable),
      .timer_done     (timer_done),
      .timer_load     (timer_load),
      .timer_count    (timer_count),
      .phy_reset_n    (phy_reset_n),
      .pwrdwn         (pwrdwn),
      .rxdet_loopb    (rxdet_loopb),
      .ts1_enable     (ts1_enable),
      .state          (train_state)
   );

   bringup_timer #(.CNT_W(CNT_W)) timer_inst (
      .rxclk(rxclk),
      .rst  (rst),
      .load (timer_load),
      .count(timer_count),
      .done (timer_done)
   );

   ts1_generator #(.N_FTS(N_FTS)) ts1_inst (
      .rxclk (rxclk),
      .rst   (rst),
      .enable(ts1_enable),
      .tx    (tx)
   );

   // PIPE pins
   assign txclk     = rxclk;      // source synchronous transmit clock
   assign txdata16  = tx.data;
   assign txdatak16 = tx.datak;
   assign txidle16  = tx.idle;
   assign txcomp    = 1'b0;       // no compliance pattern
   assign rxpol     = 1'b0;       // no polarity inversion

endmodule

// ==== rtl/pipe_pkg.sv ====
// ==========================================================
// PIPE 16-bit MAC side, low byte is the first symbol on the wire
// only the TS1 subset of the ordered-set symbols is defined here
// ==========================================================
package pipe_pkg;

   // ========================================================
   // widths
   // ========================================================
   typedef logic [7:0]  sym_t;          // one 8b symbol, before 8b/10b
   typedef logic [15:0] pipe_data_t;    // two symbols, [7:0] goes out first
   typedef logic [1:0]  pipe_datak_t;   // bit 0 flags the low symbol
   typedef logic [2:0]  rx_status_t;    // PHY rxstatus code
   typedef logic [1:0]  power_state_t;  // pwrdwn code

   // rxstatus, only the detect code is decoded
   localparam rx_status_t RX_DETECTED = 3'b011;

   // power states used during bring-up
   localparam power_state_t PWR_P0 = 2'b00;  // L0, link up
   localparam power_state_t PWR_P1 = 2'b10;  // receiver detect allowed here

   // ========================================================
   // symbols
   // ========================================================
   localparam sym_t SYM_COM      = 8'hBC;  // K28.5
   localparam sym_t SYM_PAD      = 8'hF7;  // K23.7
   localparam sym_t TS1_ID       = 8'h4A;  // D10.2
   localparam sym_t RATE_GEN1    = 8'h02;  // 2.5 GT/s only
   localparam sym_t TS_CTRL_NONE = 8'h00;  // no hot reset, no loopback

   // sequencer states, in walk order
   typedef enum logic [3:0] {
      RST_HOLD,      // phy_reset_n held low
      WAIT_PLL,      // wait for phystatus low
      SETTLE,
      DETECT,        // rxdet_loopb high in P1
      DETECT_HOLD,
      P0_GAP,
      WAIT_P0_LOW,   // phystatus fall
      WAIT_P0_HIGH,  // phystatus rise ends power change
      QUIET,
      POLLING        // TS1 while training_enable
   } train_state_t;

   // one transmit beat
   typedef struct packed {
      pipe_data_t  data;
      pipe_datak_t datak;
      logic        idle;   // electrical idle request
   } pipe_tx_t;

   // beat sent when nothing is being trained
   localparam pipe_tx_t TX_IDLE = '{data: '0, datak: '0, idle: 1'b1};

endpackage

// ==== rtl/ts1_generator.sv ====
// ==========================================================
// TS1 only, lane and link fields are PAD, training control is zero
// a started set always runs to word 7, no back-pressure
// ==========================================================
`timescale 1ns/1ps

module ts1_generator #(
   parameter logic [7:0] N_FTS = 8'hF0
) (
   input  logic               rxclk,
   input  logic               rst,
   input  logic               enable,
   output pipe_pkg::pipe_tx_t tx
);
   import pipe_pkg::*;

   logic [2:0] idx;    // word of the current set, 0 = COM word
   pipe_tx_t   word;   // beat for idx

   // ========================================================
   // word table, low byte first
   // ========================================================
   always_comb begin
      word.idle = 1'b0;
      case (idx)
         3'd0: begin
            word.data  = {SYM_PAD, SYM_COM};   // COM, link PAD
            word.datak = 2'b11;
         end
         3'd1: begin
            word.data  = {N_FTS, SYM_PAD};     // lane PAD, n_fts
            word.datak = 2'b01;
         end
         3'd2: begin
            word.data  = {TS_CTRL_NONE, RATE_GEN1};
            word.datak = 2'b00;
         end
         default: begin
            word.data  = {TS1_ID, TS1_ID};     // words 3..7
            word.datak = 2'b00;
         end
      endcase
   end

   // ========================================================
   // index walk and output register
   // ========================================================
   always_ff @(posedge rxclk) begin
      if (rst) begin
         idx <= '0;
         tx  <= TX_IDLE;
      end else if (enable || idx != 3'd0) begin
         // mid-set keeps going even with enable low
         tx  <= word;
         idx <= idx + 3'd1;   // 7 -> 0 closes the set
      end else begin
         tx  <= TX_IDLE;      // between sets, electrical idle
      end
   end

endmodule

// ==== sim/pipe_link_assertions.sv ====
// ==========================================================
// bound into pipe_link_top and counts every failure in fail_count
// waits shorter than 2 cycles are not covered
// ==========================================================
`timescale 1ns/1ps

module pipe_link_assertions #(
   parameter int         PHY_RST_CYCLES     = 64,
   parameter int         SETTLE_CYCLES      = 20,
   parameter int         DETECT_HOLD_CYCLES = 5,
   parameter int         P0_GAP_CYCLES      = 2,
   parameter int         QUIET_CYCLES       = 100,
   parameter logic [7:0] N_FTS              = 8'hF0
) (
   input logic                   rxclk,
   input logic                   rst,
   input logic                   phystatus,
   input pipe_pkg::rx_status_t   rxstatus,
   input logic                   training_enable,
   input logic                   txclk,
   input pipe_pkg::pipe_data_t   txdata16,
   input pipe_pkg::pipe_datak_t  txdatak16,
   input logic                   txidle16,
   input logic                   rxdet_loopb,
   input logic                   txcomp,
   input logic                   rxpol,
   input logic                   phy_reset_n,
   input pipe_pkg::power_state_t pwrdwn,
   input pipe_pkg::train_state_t train_state
);
   import pipe_pkg::*;

   int   fail_count = 0;    // read by the testbench
   int   txclk_edges = 0;   // rising edges seen on txclk
   logic ts_on;             // TS1 wanted this cycle
   logic word0_ok;
   logic word1_ok;
   logic word2_ok;
   logic id_ok;             // words 3..7
   logic idle_ok;           // electrical idle beat

   assign ts_on    = (train_state == POLLING) && training_enable;
   assign word0_ok = !txidle16 && txdatak16 == 2'b11 && txdata16 == {8'hF7, 8'hBC};
   assign word1_ok = !txidle16 && txdatak16 == 2'b01 && txdata16 == {N_FTS, 8'hF7};
   assign word2_ok = !txidle16 && txdatak16 == 2'b00 && txdata16 == 16'h0002;
   assign id_ok    = !txidle16 && txdatak16 == 2'b00 && txdata16 == 16'h4A4A;
   assign idle_ok  = txidle16 && txdata16 == '0 && txdatak16 == '0;

   always @(posedge txclk) begin
      txclk_edges <= txclk_edges + 1;
   end

   // ========================================================
   // reset and bring-up timing
   // ========================================================
   a_reset_vals: assert property (@(posedge rxclk) rst |=> !phy_reset_n
         && pwrdwn == PWR_P1 && !rxdet_loopb && idle_ok && !txcomp && !rxpol
         && train_state == RST_HOLD)
      else begin
         $error("outputs off reset values");
         fail_count++;
      end

   a_phy_rst: assert property (@(posedge rxclk) $fell(rst) |->
         !phy_reset_n [*PHY_RST_CYCLES] ##1 phy_reset_n)
      else begin
         $error("phy_reset_n release time");
         fail_count++;
      end

   a_settle: assert property (@(posedge rxclk) disable iff (rst)
         (train_state == WAIT_PLL && !phystatus) |=>
         !rxdet_loopb [*SETTLE_CYCLES] ##1 rxdet_loopb)
      else begin
         $error("settle length");
         fail_count++;
      end

   a_det_p1: assert property (@(posedge rxclk) disable iff (rst)
         $rose(rxdet_loopb) |-> pwrdwn == PWR_P1)
      else begin
         $error("detect outside P1");
         fail_count++;
      end

   a_det_hold: assert property (@(posedge rxclk) disable iff (rst)
         (train_state == DETECT && phystatus && rxstatus == RX_DETECTED) |=>
         rxdet_loopb [*DETECT_HOLD_CYCLES] ##1 !rxdet_loopb)
      else begin
         $error("detect hold length");
         fail_count++;
      end

   a_p0_gap: assert property (@(posedge rxclk) disable iff (rst)
         $fell(rxdet_loopb) |-> pwrdwn == PWR_P1 [*P0_GAP_CYCLES] ##1 pwrdwn == PWR_P0)
      else begin
         $error("P0 gap length");
         fail_count++;
      end

   a_quiet: assert property (@(posedge rxclk) disable iff (rst)
         (train_state == WAIT_P0_HIGH && phystatus && !$past(phystatus)) |=>
         train_state == QUIET [*QUIET_CYCLES] ##1 train_state == POLLING)
      else begin
         $error("quiet length");
         fail_count++;
      end

   // ========================================================
   // TS1 stream
   // ========================================================
   a_ts1_set: assert property (@(posedge rxclk) disable iff (rst)
         (!txidle16 && txdatak16 == 2'b11) |-> word0_ok ##1 word1_ok ##1 word2_ok
         ##1 id_ok [*5] ##1 ($past(ts_on) ? word0_ok : idle_ok))
      else begin
         $error("TS1 set content");
         fail_count++;
      end

   a_restart: assert property (@(posedge rxclk) disable iff (rst)
         (txidle16 && ts_on) |=> word0_ok)
      else begin
         $error("word 0 late after enable");
         fail_count++;
      end

   a_ties: assert property (@(posedge rxclk) !txcomp && !rxpol)
      else begin
         $error("txcomp or rxpol high");
         fail_count++;
      end

   // one txclk rise per rxclk period, sampled mid period
   a_txclk: assert property (@(negedge rxclk) disable iff (rst)
         txclk_edges == $past(txclk_edges) + 1)
      else begin
         $error("txclk not following rxclk");
         fail_count++;
      end

endmodule

bind pipe_link_top pipe_link_assertions #(
   .PHY_RST_CYCLES    (PHY_RST_CYCLES),
   .SETTLE_CYCLES     (SETTLE_CYCLES),
   .DETECT_HOLD_CYCLES(DETECT_HOLD_CYCLES),
   .P0_GAP_CYCLES     (P0_GAP_CYCLES),
   .QUIET_CYCLES      (QUIET_CYCLES),
   .N_FTS             (N_FTS)
) chk_inst (
   .rxclk(rxclk), .rst(rst), .phystatus(phystatus), .rxstatus(rxstatus),
   .training_enable(training_enable), .txclk(txclk), .txdata16(txdata16),
   .txdatak16(txdatak16), .txidle16(txidle16), .rxdet_loopb(rxdet_loopb),
   .txcomp(txcomp), .rxpol(rxpol), .phy_reset_n(phy_reset_n), .pwrdwn(pwrdwn),
   .train_state(train_state)
);

// ==== sim/pipe_link_tb.sv ====
// ==========================================================
// drives bring-up, training and reset against the bound checker
// short wait parameters on a 40 ns rxclk
// ==========================================================
`timescale 1ns/1ps

module pipe_link_tb;
   import pipe_pkg::*;

   localparam int PHY_RST = 16;
   localparam int SETTLE  = 6;
   localparam int HOLD    = 3;
   localparam int GAP     = 2;
   localparam int QUIET   = 12;
   // one bring-up with PHY delays at their 20 cycle worst case
   localparam int BRINGUP = PHY_RST + SETTLE + HOLD + GAP + QUIET + 5 * 20 + 10;
   localparam int LIMIT   = 2 * (2 * BRINGUP + 200);   // plus reset and training

   logic                 rxclk = 1'b0;
   logic                 rst;
   logic                 phystatus;
   rx_status_t           rxstatus;
   logic                 training_enable;
   logic                 txclk;
   logic                 txidle16;
   logic                 rxdet_loopb;
   logic                 txcomp;
   logic                 rxpol;
   logic                 phy_reset_n;
   pipe_data_t           txdata16;
   pipe_datak_t          txdatak16;
   power_state_t         pwrdwn;
   train_state_t         train_state;
   int                   tests = 0;

   always #20 rxclk = ~rxclk;

   pipe_link_top #(
      .PHY_RST_CYCLES(PHY_RST), .SETTLE_CYCLES(SETTLE), .DETECT_HOLD_CYCLES(HOLD),
      .P0_GAP_CYCLES(GAP), .QUIET_CYCLES(QUIET), .N_FTS(8'hF0), .CNT_W(8)
   ) pipe_link_top_inst (.*);

   pipe_phy_model phy_inst (
      .rxclk(rxclk), .phy_reset_n(phy_reset_n), .pwrdwn(pwrdwn),
      .rxdet_loopb(rxdet_loopb), .phystatus(phystatus), .rxstatus(rxstatus)
   );

   task automatic cycles(input int n);
      repeat (n) @(posedge rxclk);
      #1;
   endtask

   task automatic wait_state(input train_state_t st);
      do @(posedge rxclk); while (train_state != st);
      #1;
   endtask

   task automatic test_done(input string name);
      tests++;
      $display("test %0d %s done, assertion failures so far %0d",
               tests, name, pipe_link_top_inst.chk_inst.fail_count);
   endtask

   // 10 cycles of rst, bring-up starts when it drops
   task automatic apply_reset();
      rst = 1'b1;
      cycles(10);
      rst = 1'b0;
   endtask

   // ========================================================
   // sequence
   // ========================================================
   initial begin
      training_enable = 1'b0;
      rst             = 1'b1;
      apply_reset();
      wait_state(WAIT_PLL);
      test_done("reset values");
      wait_state(P0_GAP);
      test_done("receiver detect");
      wait_state(POLLING);
      test_done("power change");
      training_enable = 1'b1;
      cycles(3 * 8 + 2);             // several sets back to back
      test_done("TS1 content");
      do @(posedge rxclk); while (txdatak16 != 2'b11);
      cycles(3);
      training_enable = 1'b0;        // drop mid set
      do @(posedge rxclk); while (!txidle16);
      cycles(4);
      training_enable = 1'b1;        // restart from idle
      cycles(20);
      training_enable = 1'b0;
      cycles(12);
      test_done("stop and restart");
      training_enable = 1'b1;
      cycles(5);                     // part way into a set
      apply_reset();                 // enable stays high through reset
      wait_state(POLLING);
      cycles(20);
      training_enable = 1'b0;
      cycles(12);
      test_done("reset during training");
      $display("tests run %0d, assertion failures %0d",
               tests, pipe_link_top_inst.chk_inst.fail_count);
      if (pipe_link_top_inst.chk_inst.fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (LIMIT) @(posedge rxclk);
      $display("watchdog expired after %0d cycles, sequence did not complete", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== sim/pipe_phy_model.sv ====
// ==========================================================
// behavioral PHY, answers one bring-up per phy_reset_n pulse
// outputs change 1 ns after the rising rxclk edge
// ==========================================================
`timescale 1ns/1ps

module pipe_phy_model (
   input  logic                   rxclk,
   input  logic                   phy_reset_n,
   input  pipe_pkg::power_state_t pwrdwn,
   input  logic                   rxdet_loopb,
   output logic                   phystatus,
   output pipe_pkg::rx_status_t   rxstatus
);
   import pipe_pkg::*;

   logic [15:0] lfsr = 16'd39491;   // fixed seed

   // fibonacci, taps 16 14 13 11, one step per bit taken
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // 5..20 cycles from four fresh bits
   task automatic random_delay(output int d);
      int bits;
      bits = 0;
      for (int i = 0; i < 4; i++) begin
         lfsr = lfsr_step(lfsr);
         bits = (bits << 1) | int'(lfsr[0]);
      end
      d = 5 + bits;
   endtask

   task automatic cycles(input int n);
      repeat (n) @(posedge rxclk);
      #1;
   endtask

   initial begin
      int d;
      phystatus = 1'b1;   // high while in reset
      rxstatus  = '0;
      forever begin
         phystatus = 1'b1;
         wait (phy_reset_n === 1'b1);
         random_delay(d);
         cycles(d);
         phystatus = 1'b0;          // PLL locked
         // ====================================================
         // receiver detect
         // ====================================================
         wait (rxdet_loopb === 1'b1);
         random_delay(d);
         cycles(d);
         phystatus = 1'b1;
         rxstatus  = RX_DETECTED;   // one-cycle detect pulse
         cycles(1);
         phystatus = 1'b0;
         rxstatus  = '0;
         // ====================================================
         // power change to P0
         // ====================================================
         wait (pwrdwn === PWR_P0);
         random_delay(d);
         cycles(d);
         phystatus = 1'b1;          // busy
         random_delay(d);
         cycles(d);
         phystatus = 1'b0;
         random_delay(d);
         cycles(d);
         phystatus = 1'b1;          // completion pulse
         cycles(1);
         phystatus = 1'b0;
         wait (phy_reset_n === 1'b0);
      end
   end

endmodule

// ==== src.f ====
rtl/pipe_pkg.sv
rtl/bringup_timer.sv
rtl/pipe_bringup_fsm.sv
rtl/ts1_generator.sv
rtl/pipe_link_top.sv
sim/pipe_phy_model.sv
sim/pipe_link_assertions.sv
sim/pipe_link_tb.sv
